// File: usbRx.f
usbRxPkg.sv
usbRxSync.sv
dppl.sv
nrziUnstuff.sv
usbRxDeser.sv
usbRxTop.sv
tbUsbRx.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbUsbRx
FILELIST = usbRx.f
LOG      = sim.log

.PHONY: sim clean

# The log decides pass or fail, since the simulator exits cleanly either way
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tbUsbRx.sv
// Drives D+ only, 4-cycle bits on a 40 ns clock; packets close with a J tail, not a real EOP
`timescale 1ns/10ps

module tbUsbRx;

    localparam int bitCycles = usbRxPkg::cyclesPerBit;
    // Room for a closing zero plus idleLimit ones
    localparam int tailBits = usbRxPkg::idleLimit + 4;
    localparam int gapBits = 4;
    // Reset, idle case, six packets, 32 payload bytes at up to 10 bit times each
    localparam int budgetBits = 3 + 50 + 6 * (8 + tailBits + gapBits) + 10 * 32;
    localparam int watchdogNs = 2 * budgetBits * bitCycles * 40;

    logic clk48;
    logic rst;
    logic dp;
    logic [7:0] rxByte;
    logic rxByteValid;
    logic pktActive;
    logic stuffErr;

    // Encoder state
    bit lineBits[$];
    int runOnes;
    int drift;
    int lastWidth;
    logic [31:0] lcgState;

    // Monitor records, cleared per case
    logic [7:0] rxBytes[$];
    int byteRise[$];
    int errAtByte[$];
    int pktRises;
    int strayBytes;
    logic activePrev;

    logic [7:0] expBytes[$];
    int caseErrors;
    int failCount;
    int casesRun;
    int casesFailed;

    usbRxTop i_usbRxTop (
        .clk48_i     (clk48),
        .rst_i       (rst),
        .dp_i        (dp),
        .byte_o      (rxByte),
        .byteValid_o (rxByteValid),
        .pktActive_o (pktActive),
        .stuffErr_o  (stuffErr)
    );

    initial begin
        clk48 = 1'b0;
        forever #20 clk48 = ~clk48;
    end

    // Outputs move on the rising edge, so the falling edge sees them settled
    always @(negedge clk48) begin
        if (!rst) begin
            if (pktActive && !activePrev) begin
                pktRises++;
            end
            activePrev = pktActive;
            if (rxByteValid) begin
                rxBytes.push_back(rxByte);
                // Tag each byte with the packet it came in
                byteRise.push_back(pktRises);
                if (!pktActive) begin
                    strayBytes++;
                end
            end
            if (stuffErr) begin
                errAtByte.push_back(rxBytes.size());
            end
        end
    end

    function automatic logic [7:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    // Bit width for the drift case
    // Phase error kept within one cycle, no two short or long bits back to back
    function automatic int drawWidth();
        int pick;
        int w;
        pick = int'(lcgNext() % 8'd3);
        w = bitCycles;
        if (pick == 0 && drift >= 0 && lastWidth != bitCycles - 1) begin
            w = bitCycles - 1;
        end else if (pick == 2 && drift <= 0 && lastWidth != bitCycles + 1) begin
            w = bitCycles + 1;
        end
        drift += w - bitCycles;
        lastWidth = w;
        return w;
    endfunction

    // Ones are counted across SYNC and payload alike
    task automatic appendBit(input bit b, input bit stuffOn);
        lineBits.push_back(b);
        if (!b) begin
            runOnes = 0;
        end else begin
            runOnes++;
            if (stuffOn && runOnes == usbRxPkg::stuffLimit) begin
                lineBits.push_back(1'b0);
                runOnes = 0;
            end
        end
    endtask

    task automatic appendByte(input logic [7:0] b);
        // LSB first on the wire
        for (int i = 0; i < 8; i++) begin
            appendBit(b[i], 1'b1);
        end
    endtask

    task automatic startPacket();
        lineBits.delete();
        runOnes = 0;
        for (int i = 0; i < 8; i++) begin
            appendBit(usbRxPkg::syncByte[i], 1'b1);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic driveBit(input logic level, input int cycles);
        dp = level;
        repeat (cycles) @(posedge clk48);
        #2;
    endtask

    // NRZI from idle J, a zero toggles the line
    task automatic sendPacket(input bit jitter, input int tail);
        logic level;
        int w;
        level = 1'b1;
        drift = 0;
        lastWidth = bitCycles;
        foreach (lineBits[i]) begin
            if (!lineBits[i]) begin
                level = ~level;
            end
            w = jitter ? drawWidth() : bitCycles;
            driveBit(level, w);
        end
        driveBit(1'b1, tail * bitCycles);
    endtask

    task automatic waitIdle(input string name);
        int n;
        n = 0;
        while (pktActive && n < tailBits * bitCycles) begin
            @(posedge clk48);
            n++;
        end
        // Let the last strobes reach the monitor
        repeat (gapBits * bitCycles) @(posedge clk48);
        #2;
        assert (!pktActive) else begin
            $display("%s: pktActive_o never fell after the idle tail", name);
            caseErrors++;
        end
    endtask

    task automatic startCase();
        rxBytes.delete();
        byteRise.delete();
        errAtByte.delete();
        expBytes.delete();
        pktRises = 0;
        strayBytes = 0;
        caseErrors = 0;
    endtask

    task automatic closeCase(input string name);
        casesRun++;
        if (caseErrors != 0) begin
            casesFailed++;
            failCount += caseErrors;
        end
        $display("case %s finished with %0d error(s)", name, caseErrors);
    endtask

    task automatic checkBytes(input string name);
        int n;
        n = (rxBytes.size() < expBytes.size()) ? rxBytes.size() : expBytes.size();
        assert (rxBytes.size() == expBytes.size()) else begin
            $display("%s: %0d bytes arrived where %0d were sent",
                     name, rxBytes.size(), expBytes.size());
            caseErrors++;
        end
        for (int i = 0; i < n; i++) begin
            assert (rxBytes[i] == expBytes[i]) else begin
                $display("[FAIL] %s: byte %0d expected 0x%02h, actual 0x%02h",
                         name, i, expBytes[i], rxBytes[i]);
                caseErrors++;
            end
        end
        assert (strayBytes == 0) else begin
            $display("%s: a byte strobe came while pktActive_o was low", name);
            caseErrors++;
        end
    endtask

    task automatic idleLine();
        startCase();
        driveBit(1'b1, 200);
        assert (rxBytes.size() == 0 && pktRises == 0 && errAtByte.size() == 0) else begin
            $display("idle line: outputs moved while the line stayed at J");
            caseErrors++;
        end
        closeCase("idle line");
    endtask

    task automatic simplePacket();
        startCase();
        startPacket();
        // No run of six ones anywhere
        expBytes = '{8'h3C, 8'hA5, 8'h12, 8'hC3};
        foreach (expBytes[i]) begin
            appendByte(expBytes[i]);
        end
        sendPacket(1'b0, tailBits);
        waitIdle("simple packet");
        checkBytes("simple packet");
        assert (pktRises == 1) else begin
            $display("simple packet: pktActive_o rose %0d times for one packet", pktRises);
            caseErrors++;
        end
        closeCase("simple packet");
    endtask

    task automatic stuffRemoved();
        startCase();
        startPacket();
        expBytes = '{8'hFF, 8'h7E};
        foreach (expBytes[i]) begin
            appendByte(expBytes[i]);
        end
        sendPacket(1'b0, tailBits);
        waitIdle("stuff removed");
        checkBytes("stuff removed");
        // The idle tail itself overflows the run, only pulses inside the payload count
        foreach (errAtByte[i]) begin
            assert (errAtByte[i] >= expBytes.size()) else begin
                $display("stuff removed: stuffErr_o pulsed inside the payload");
                caseErrors++;
            end
        end
        closeCase("stuff removed");
    endtask

    task automatic stuffError();
        int early;
        startCase();
        startPacket();
        appendByte(8'h00);
        // Seven ones with the stuffed zero left out
        for (int i = 0; i < 7; i++) begin
            appendBit(1'b1, 1'b0);
        end
        appendBit(1'b0, 1'b1);
        appendBit(1'b0, 1'b1);
        appendByte(8'h00);
        sendPacket(1'b0, tailBits);
        waitIdle("stuff error");
        early = 0;
        foreach (errAtByte[i]) begin
            if (errAtByte[i] < 3) begin
                early++;
            end
        end
        assert (early > 0) else begin
            $display("stuff error: no stuffErr_o pulse inside the packet");
            caseErrors++;
        end
        closeCase("stuff error");
    endtask

    task automatic clockDrift();
        logic [7:0] b;
        startCase();
        startPacket();
        for (int i = 0; i < 16; i++) begin
            b = lcgNext();
            expBytes.push_back(b);
            appendByte(b);
        end
        sendPacket(1'b1, tailBits);
        waitIdle("clock drift");
        checkBytes("clock drift");
        closeCase("clock drift");
    endtask

    task automatic backToBack();
        logic [7:0] b;
        startCase();
        for (int p = 0; p < 2; p++) begin
            startPacket();
            for (int i = 0; i < 3; i++) begin
                b = lcgNext();
                expBytes.push_back(b);
                appendByte(b);
            end
            // First tail is the shortest that still closes the packet
            sendPacket(1'b0, (p == 0) ? usbRxPkg::idleLimit + 1 : tailBits);
        end
        waitIdle("back to back");
        checkBytes("back to back");
        assert (pktRises == 2) else begin
            $display("back to back: pktActive_o rose %0d times for two packets", pktRises);
            caseErrors++;
        end
        foreach (byteRise[i]) begin
            assert (byteRise[i] == ((i < 3) ? 1 : 2)) else begin
                $display("back to back: byte %0d landed in the wrong packet", i);
                caseErrors++;
            end
        end
        closeCase("back to back");
    endtask

    initial begin
        rst = 1'b1;
        dp = 1'b1;
        activePrev = 1'b0;
        lcgState = 32'd78216;
        pktRises = 0;
        strayBytes = 0;
        failCount = 0;
        casesRun = 0;
        casesFailed = 0;
        repeat (10) @(posedge clk48);
        #2;
        rst = 1'b0;
        idleLine();
        simplePacket();
        stuffRemoved();
        stuffError();
        clockDrift();
        backToBack();
        $display("cases run %0d, cases failed %0d, checks failed %0d",
                 casesRun, casesFailed, failCount);
        if (failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Twice the bit time of all cases together
    initial begin
        #(watchdogNs);
        $display("watchdog expired before all cases finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: usbRxTop.sv
// Full-speed receive front end on D+ only; no EOP, PID or CRC checks and no back-pressure
`timescale 1ns/10ps

module usbRxTop (
    input  logic       clk48_i,
    input  logic       rst_i,
    input  logic       dp_i,
    output logic [7:0] byte_o,
    output logic       byteValid_o,
    output logic       pktActive_o,
    output logic       stuffErr_o
);

    // Synchronized line, both edges
    logic dpPos;
    logic dpNeg;
    // Recovered bit clock and lock
    logic rxClk12;
    logic gotSignal;
    // Decoded bit stream
    logic bitValid;
    logic bitData;
    logic oneRun;
    logic stuffErr;

    usbRxSync i_usbRxSync (
        .clk48_i (clk48_i),
        .rst_i   (rst_i),
        .dp_i    (dp_i),
        .dpPos_o (dpPos),
        .dpNeg_o (dpNeg)
    );

    dppl i_dppl (
        .clk48_i         (clk48_i),
        .rst_i           (rst_i),
        .dpPosEdgeSync_i (dpPos),
        .dpNegEdgeSync_i (dpNeg),
        .rxClk12_o       (rxClk12),
        .gotSignal_o     (gotSignal)
    );

    nrziUnstuff i_nrziUnstuff (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .rxClk12_i   (rxClk12),
        .dpPos_i     (dpPos),
        .gotSignal_i (gotSignal),
        .bitValid_o  (bitValid),
        .bitData_o   (bitData),
        .oneRun_o    (oneRun),
        .stuffErr_o  (stuffErr)
    );

    usbRxDeser i_usbRxDeser (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .bitValid_i  (bitValid),
        .bitData_i   (bitData),
        .oneRun_i    (oneRun),
        .stuffErr_i  (stuffErr),
        .byte_o      (byte_o),
        .byteValid_o (byteValid_o),
        .pktActive_o (pktActive_o),
        .stuffErr_o  (stuffErr_o)
    );

endmodule

// File: usbRxDeser.sv
// LSB-first bytes after SYNC; the packet ends on idleLimit ones, a partial byte is dropped
`timescale 1ns/10ps

module usbRxDeser (
    input  logic       clk48_i,
    input  logic       rst_i,
    input  logic       bitValid_i,
    input  logic       bitData_i,
    input  logic       oneRun_i,
    input  logic       stuffErr_i,
    output logic [7:0] byte_o,
    output logic       byteValid_o,
    output logic       pktActive_o,
    output logic       stuffErr_o
);

    localparam logic [3:0] idleLast = 4'(usbRxPkg::idleLimit - 1);
    localparam logic [3:0] stuffRun = 4'(usbRxPkg::stuffLimit);

    logic [7:0] window;
    logic [7:0] shiftReg;
    logic [7:0] nextWindow;
    logic [7:0] nextShift;
    logic [2:0] bitCnt;
    logic [3:0] idleCnt;
    logic runRestart;
    logic endPkt;

    assign nextWindow = {bitData_i, window[7:1]};
    assign nextShift = {bitData_i, shiftReg[7:1]};

    // A kept one after a full stuffing run means a stuffed zero fell in between
    assign runRestart = oneRun_i & bitValid_i & (idleCnt == stuffRun);
    assign endPkt = pktActive_o & oneRun_i & ~runRestart & (idleCnt == idleLast);

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            window <= 8'd0;
            bitCnt <= 3'd0;
            idleCnt <= 4'd0;
            byteValid_o <= 1'b0;
            pktActive_o <= 1'b0;
            stuffErr_o <= 1'b0;
        end else begin
            byteValid_o <= 1'b0;
            stuffErr_o <= stuffErr_i;
            if (!pktActive_o) begin
                // Hunt for SYNC
                if (bitValid_i) begin
                    window <= nextWindow;
                    if (nextWindow == usbRxPkg::syncByte) begin
                        pktActive_o <= 1'b1;
                        bitCnt <= 3'd0;
                        idleCnt <= 4'd0;
                    end
                end
            end else if (endPkt) begin
                // Idle J long enough, back to hunting
                pktActive_o <= 1'b0;
                window <= 8'd0;
            end else begin
                // Idle run bookkeeping
                if (runRestart) begin
                    idleCnt <= 4'd1;
                end else if (oneRun_i) begin
                    idleCnt <= idleCnt + 4'd1;
                end else if (bitValid_i) begin
                    idleCnt <= 4'd0;
                end
                // Byte assembly
                if (bitValid_i) begin
                    shiftReg <= nextShift;
                    bitCnt <= bitCnt + 3'd1;
                    if (bitCnt == 3'd7) begin
                        byte_o <= nextShift;
                        byteValid_o <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: nrziUnstuff.sv
// NRZI decode and unstuffing; the 7th one of the idle tail after a packet raises stuffErr_o
`timescale 1ns/10ps

module nrziUnstuff (
    input  logic clk48_i,
    input  logic rst_i,
    input  logic rxClk12_i,
    input  logic dpPos_i,
    input  logic gotSignal_i,
    output logic bitValid_o,
    output logic bitData_o,
    output logic oneRun_o,
    output logic stuffErr_o
);

    // Count of consecutive ones
    // stuffLimit means a stuffed zero is due
    // stuffLimit+1 means the run overflowed (error or idle)
    localparam logic [2:0] stuffDue = 3'(usbRxPkg::stuffLimit);
    localparam logic [2:0] runOver = 3'(usbRxPkg::stuffLimit + 1);

    logic clkPrev;
    logic started;
    logic samplePrev;
    logic [2:0] onesCnt;
    logic clkRise;
    logic decoded;

    // Sample point of each bit
    assign clkRise = rxClk12_i & ~clkPrev;

    // NRZI: no change on the line is a one
    assign decoded = ~(dpPos_i ^ samplePrev);

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            clkPrev <= 1'b0;
            started <= 1'b0;
            samplePrev <= 1'b1;
            onesCnt <= 3'd0;
            bitValid_o <= 1'b0;
            oneRun_o <= 1'b0;
            stuffErr_o <= 1'b0;
        end else begin
            clkPrev <= rxClk12_i;
            bitValid_o <= 1'b0;
            oneRun_o <= 1'b0;
            stuffErr_o <= 1'b0;
            if (!started) begin
                // Idle until the DPLL has locked on the first K
                // That K becomes the NRZI reference level
                samplePrev <= dpPos_i;
                started <= gotSignal_i;
            end else if (clkRise) begin
                samplePrev <= dpPos_i;
                if (decoded) begin
                    oneRun_o <= 1'b1;
                    if (onesCnt < stuffDue) begin
                        bitValid_o <= 1'b1;
                        bitData_o <= 1'b1;
                        onesCnt <= onesCnt + 3'd1;
                    end else if (onesCnt == stuffDue) begin
                        // A one where the stuffed zero belongs
                        stuffErr_o <= 1'b1;
                        onesCnt <= runOver;
                    end
                end else begin
                    onesCnt <= 3'd0;
                    // Stuffed zero is dropped
                    // after an overflowed run the zero is real data
                    if (onesCnt != stuffDue) begin
                        bitValid_o <= 1'b1;
                        bitData_o <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: dppl.sv
// 12-state Gray-coded DPLL at 4x oversampling; tracks jitter of about one clock per bit
`timescale 1ns/10ps

module dppl (
    input  logic clk48_i,
    input  logic rst_i,
    input  logic dpPosEdgeSync_i,
    input  logic dpNegEdgeSync_i,
    output logic rxClk12_o,
    output logic gotSignal_o
);

    // Bit 1 of every code is the recovered clock
    // Bit 3 marks the init and swap states
    // Bit 2 selects the right loop
    typedef enum logic [3:0] {
        // Waiting for the first K
        stateC = 4'b1100,
        stateD = 4'b1101,
        // Crossing from one loop to the other
        stateB = 4'b1011,
        stateF = 4'b1111,
        // Right loop
        state5 = 4'b0101,
        state7 = 4'b0111,
        state6 = 4'b0110,
        state4 = 4'b0100,
        // Left loop, entered after a received zero
        state1 = 4'b0001,
        state3 = 4'b0011,
        state2 = 4'b0010,
        state0 = 4'b0000
    } stateT;

    stateT state;
    logic [3:0] grayStep;
    logic [3:0] nextBits;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state <= stateC;
        end else begin
            state <= stateT'(nextBits);
        end
    end

    // Free-running step around a loop, one Gray-code move per clock
    assign grayStep = {state[3:2], state[0], ~state[1]};

    always_comb begin
        nextBits = grayStep;
        case (state)
            // Hold while the line idles at J
            stateC: begin
                if (state[0] ^ dpNegEdgeSync_i) begin
                    nextBits = state;
                end
            end
            // First K seen, hold until it ends
            stateD: begin
                if (state[0] ^ dpNegEdgeSync_i) begin
                    nextBits = state;
                end else begin
                    nextBits = {1'b0, state[2:0]};
                end
            end
            // Leave the swap state into the other loop
            stateF, stateB: begin
                nextBits[3] = 1'b0;
            end
            // Early edge on the line, swap loops via B or F
            state7, state3: begin
                if (dpPosEdgeSync_i ^ state[2]) begin
                    nextBits = {~state[3], ~state[2], state[0], state[1]};
                end
            end
            // Edge near the clock high phase, pull the phase back into the other loop
            state6, state2: begin
                if (dpNegEdgeSync_i ^ state[2]) begin
                    nextBits = {state[3], ~state[2], state[0], state[1]};
                end
            end
            // Late edge, step across to the other loop
            state4, state0: begin
                if (dpNegEdgeSync_i ^ state[2]) begin
                    nextBits[2] = ~state[2];
                end
            end
            // States 1 and 5 and unused codes take the plain step
            default: begin
                nextBits = grayStep;
            end
        endcase
    end

    assign rxClk12_o = state[1];

    // Locked on a received zero: init D or anywhere in the left loop
    assign gotSignal_o = (state == stateD) || (state[3:2] == 2'b00);

endmodule

// File: usbRxSync.sv
// D+ only, no D- or SE0; chains reset to J (high); dp_i may be fully asynchronous to clk48_i
`timescale 1ns/10ps

module usbRxSync (
    input  logic clk48_i,
    input  logic rst_i,
    input  logic dp_i,
    output logic dpPos_o,
    output logic dpNeg_o
);

    // One chain per clock edge, newest sample in bit 0
    logic [usbRxPkg::syncStages-1:0] posChain;
    logic [usbRxPkg::syncStages-1:0] negChain;

    // Rising-edge chain
    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            // Idle J level
            posChain <= '1;
        end else begin
            posChain <= {posChain[usbRxPkg::syncStages-2:0], dp_i};
        end
    end

    // Falling-edge chain, gives the DPLL half-cycle resolution
    always_ff @(negedge clk48_i) begin
        if (rst_i) begin
            negChain <= '1;
        end else begin
            negChain <= {negChain[usbRxPkg::syncStages-2:0], dp_i};
        end
    end

    // Oldest stage is the synchronized line
    assign dpPos_o = posChain[usbRxPkg::syncStages-1];
    assign dpNeg_o = negChain[usbRxPkg::syncStages-1];

endmodule

// File: usbRxPkg.sv
// Line-coding constants for the full-speed receive chain; assumes a 48 MHz clock, 4x bit rate
package usbRxPkg;

    // Flops in each input synchronizer chain
    localparam int unsigned syncStages = 2;

    // Decoded ones after which the transmitter inserts a zero
    localparam int unsigned stuffLimit = 6;

    // SYNC as decoded bits KJKJKJKK, LSB first
    // Seven zeros then a one
    localparam logic [7:0] syncByte = 8'h80;

    // Consecutive decoded ones that close a packet
    // Stands in for a real EOP, since SE0 is not observed
    // Wider than stuffLimit, so the 7th one is already a stuffing error
    localparam int unsigned idleLimit = 8;

    // Operating point of the design
    // 48 MHz sampling of a 12 Mb/s line gives 4 clocks per bit
    // The DPLL tolerates single bits of 3 or 5 clocks
    localparam int unsigned cyclesPerBit = 4;

endpackage
